/* hw/mini_pkg.sv */
// Accumulator subsystem definitions

package mini_pkg;

    // memory map
    localparam int RAM_ADDR_WIDTH = 16;
    localparam int RAM_WORDS = 2 ** (RAM_ADDR_WIDTH - 2);

    localparam logic [31:0] BOOT_ADDR = 32'h0000_0000;
    localparam logic [23:0] PRINT_ADDR = 24'h80_0000;
    localparam logic [23:0] EXIT_ADDR = 24'h80_0004;

    // operation codes, upper byte of every instruction
    typedef enum logic [7:0] {
        OP_NOP  = 8'h00,
        OP_LDI  = 8'h01,
        OP_ADDI = 8'h02,
        OP_LD   = 8'h03,
        OP_ADD  = 8'h04,
        OP_ST   = 8'h05,
        OP_BNZ  = 8'h06,
        OP_JMP  = 8'h07
    } opcode_e;

    // operand is a byte address, or a signed immediate for OP_LDI and OP_ADDI
    typedef struct packed {
        opcode_e     opcode;
        logic [23:0] operand;
    } instr_t;

    // data port request payload
    typedef struct packed {
        logic        we;
        logic [31:0] addr;
        logic [31:0] wdata;
    } data_req_t;

    // program load strobe payload
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } load_t;

endpackage

/* hw/mini_core.sv */
// Accumulator core

`timescale 1ns/1ns

module mini_core import mini_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,

    input  logic        fetch_enable_i,

    output logic        instr_req_o,
    output logic [31:0] instr_addr_o,
    input  logic        instr_gnt_i,
    input  instr_t      instr_rdata_i,
    input  logic        instr_rvalid_i,

    output logic        data_req_o,
    output data_req_t   data_req_o_bits,
    input  logic        data_gnt_i,
    input  logic [31:0] data_rdata_i,
    input  logic        data_rvalid_i
);

    typedef enum logic [1:0] {
        IDLE,
        EXEC,
        WAIT_DATA
    } state_e;

    // fetch stage
    logic        running_q;
    logic        req_q;
    logic [31:0] addr_q;
    logic [31:0] fetch_pc_q;
    logic        pend_q;
    logic        kill_q;
    logic        ibuf_valid_q;
    instr_t      ibuf_q;

    // execute stage
    state_e      state_q;
    instr_t      ir_q;
    logic [31:0] acc_q;
    logic [31:0] imm;
    logic [31:0] target;
    logic        taken;
    logic        mem_op;
    logic        consume;
    logic        fetch_en;
    logic        issue;

    assign fetch_en = running_q | fetch_enable_i;
    assign consume  = (state_q == IDLE) && ibuf_valid_q;

    // one fetch in flight at a time, and only when the buffer has room
    assign issue = fetch_en && !req_q && !pend_q && (!ibuf_valid_q || consume) && !taken;

    assign instr_req_o  = req_q;
    assign instr_addr_o = addr_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            running_q  <= 1'b0;
            req_q      <= 1'b0;
            addr_q     <= BOOT_ADDR;
            fetch_pc_q <= BOOT_ADDR;
            pend_q     <= 1'b0;
            kill_q     <= 1'b0;
        end else begin
            running_q <= fetch_en;

            if (issue) begin
                req_q      <= 1'b1;
                addr_q     <= fetch_pc_q;
                fetch_pc_q <= fetch_pc_q + 32'd4;
            end else if (req_q && instr_gnt_i) begin
                req_q <= 1'b0;
            end

            if (taken) begin
                fetch_pc_q <= target;
            end

            if (req_q && instr_gnt_i) begin
                pend_q <= 1'b1;
            end else if (instr_rvalid_i) begin
                pend_q <= 1'b0;
            end

            // a fetch still in flight at a redirect belongs to the old path
            if (taken && (req_q || (pend_q && !instr_rvalid_i))) begin
                kill_q <= 1'b1;
            end else if (instr_rvalid_i) begin
                kill_q <= 1'b0;
            end
        end
    end

    // instruction buffer
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ibuf_valid_q <= 1'b0;
        end else if (taken) begin
            ibuf_valid_q <= 1'b0;
        end else if (instr_rvalid_i && !kill_q) begin
            ibuf_valid_q <= 1'b1;
        end else if (consume) begin
            ibuf_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (instr_rvalid_i && !kill_q && !taken) begin
            ibuf_q <= instr_rdata_i;
        end
        if (consume) begin
            ir_q <= ibuf_q;
        end
    end

    // decode
    assign imm    = {{8{ir_q.operand[23]}}, ir_q.operand};
    assign target = {8'h00, ir_q.operand};

    always_comb begin
        taken  = 1'b0;
        mem_op = 1'b0;
        if (state_q == EXEC) begin
            case (ir_q.opcode)
                OP_JMP:              taken = 1'b1;
                OP_BNZ:              taken = (acc_q != 32'd0);
                OP_LD, OP_ADD, OP_ST: mem_op = 1'b1;
                default: ;
            endcase
        end
    end

    assign data_req_o            = mem_op;
    assign data_req_o_bits.we    = (ir_q.opcode == OP_ST);
    assign data_req_o_bits.addr  = target;
    assign data_req_o_bits.wdata = acc_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            acc_q   <= 32'd0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (ibuf_valid_q) begin
                        state_q <= EXEC;
                    end
                end
                EXEC: begin
                    if (ir_q.opcode == OP_LDI) begin
                        acc_q <= imm;
                    end else if (ir_q.opcode == OP_ADDI) begin
                        acc_q <= acc_q + imm;
                    end
                    // memory ops wait here for the grant
                    if (!mem_op) begin
                        state_q <= IDLE;
                    end else if (data_gnt_i) begin
                        state_q <= WAIT_DATA;
                    end
                end
                WAIT_DATA: begin
                    if (data_rvalid_i) begin
                        if (ir_q.opcode == OP_LD) begin
                            acc_q <= data_rdata_i;
                        end else if (ir_q.opcode == OP_ADD) begin
                            acc_q <= acc_q + data_rdata_i;
                        end
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // requests stay put until the memory takes them
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o));

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        data_req_o && !data_gnt_i |=> data_req_o && $stable(data_req_o_bits));

    // responses only for requests the memory accepted
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        instr_rvalid_i |-> pend_q);

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        data_rvalid_i |-> (state_q == WAIT_DATA));

endmodule

/* hw/mm_ram.sv */
// Memory-mapped RAM with pseudo peripherals

`timescale 1ns/1ns

module mm_ram import mini_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,

    input  logic        load_valid_i,
    input  load_t       load_i,

    input  logic        instr_req_i,
    input  logic [31:0] instr_addr_i,
    output logic        instr_gnt_o,
    output instr_t      instr_rdata_o,
    output logic        instr_rvalid_o,

    input  logic        data_req_i,
    input  data_req_t   data_req_i_bits,
    output logic        data_gnt_o,
    output logic [31:0] data_rdata_o,
    output logic        data_rvalid_o,

    output logic        print_valid_o,
    output logic [7:0]  print_char_o,
    output logic        tests_passed_o,
    output logic        tests_failed_o,
    output logic        exit_valid_o,
    output logic [31:0] exit_value_o
);

    logic [31:0] mem [RAM_WORDS];

    logic        instr_in_ram;
    logic        data_in_ram;
    logic        load_in_ram;
    logic        data_is_print;
    logic        data_is_exit;
    logic        data_wr;

    logic        ram_we;
    logic [31:0] ram_addr;
    logic [31:0] ram_wdata;
    logic [31:0] ram_rdata_q;

    logic        instr_hit_q;
    logic        data_hit_q;

    // address decode
    assign instr_in_ram  = (instr_addr_i[31:RAM_ADDR_WIDTH] == '0);
    assign data_in_ram   = (data_req_i_bits.addr[31:RAM_ADDR_WIDTH] == '0);
    assign load_in_ram   = (load_i.addr[31:RAM_ADDR_WIDTH] == '0);
    assign data_is_print = (data_req_i_bits.addr == {8'h00, PRINT_ADDR});
    assign data_is_exit  = (data_req_i_bits.addr == {8'h00, EXIT_ADDR});

    // load port first, then data, then instruction
    assign data_gnt_o  = data_req_i && !load_valid_i;
    assign instr_gnt_o = instr_req_i && !data_req_i && !load_valid_i;
    assign data_wr     = data_gnt_o && data_req_i_bits.we;

    always_comb begin
        if (load_valid_i) begin
            ram_addr  = load_i.addr;
            ram_wdata = load_i.data;
            ram_we    = load_in_ram;
        end else if (data_req_i) begin
            ram_addr  = data_req_i_bits.addr;
            ram_wdata = data_req_i_bits.wdata;
            ram_we    = data_wr && data_in_ram;
        end else begin
            ram_addr  = instr_addr_i;
            ram_wdata = data_req_i_bits.wdata;
            ram_we    = 1'b0;
        end
    end

    // single port array
    always_ff @(posedge clk_i) begin
        if (ram_we) begin
            mem[ram_addr[RAM_ADDR_WIDTH-1:2]] <= ram_wdata;
        end
        ram_rdata_q <= mem[ram_addr[RAM_ADDR_WIDTH-1:2]];
        instr_hit_q <= instr_in_ram;
        data_hit_q  <= data_in_ram && !data_req_i_bits.we;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            instr_rvalid_o <= 1'b0;
            data_rvalid_o  <= 1'b0;
        end else begin
            instr_rvalid_o <= instr_gnt_o;
            data_rvalid_o  <= data_gnt_o;
        end
    end

    // unmapped reads and all writes answer zero
    assign instr_rdata_o = instr_hit_q ? instr_t'(ram_rdata_q) : instr_t'(32'd0);
    assign data_rdata_o  = data_hit_q ? ram_rdata_q : 32'd0;

    // character output
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            print_valid_o <= 1'b0;
        end else begin
            print_valid_o <= data_wr && data_is_print;
        end
    end

    always_ff @(posedge clk_i) begin
        if (data_wr && data_is_print) begin
            print_char_o <= data_req_i_bits.wdata[7:0];
        end
    end

    // exit port keeps the first value until reset
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            exit_valid_o   <= 1'b0;
            exit_value_o   <= 32'd0;
            tests_passed_o <= 1'b0;
            tests_failed_o <= 1'b0;
        end else if (data_wr && data_is_exit && !exit_valid_o) begin
            exit_valid_o   <= 1'b1;
            exit_value_o   <= data_req_i_bits.wdata;
            tests_passed_o <= (data_req_i_bits.wdata == 32'd0);
            tests_failed_o <= (data_req_i_bits.wdata != 32'd0);
        end
    end

    // print strobe lasts one cycle
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        print_valid_o |=> !print_valid_o);

endmodule

/* hw/mini_subsystem.sv */
// Core and memory subsystem

`timescale 1ns/1ns

module mini_subsystem import mini_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,

    input  logic        fetch_enable_i,
    input  logic        load_valid_i,
    input  load_t       load_i,

    output logic        print_valid_o,
    output logic [7:0]  print_char_o,
    output logic        tests_passed_o,
    output logic        tests_failed_o,
    output logic        exit_valid_o,
    output logic [31:0] exit_value_o
);

    // instruction port
    logic        instr_req;
    logic [31:0] instr_addr;
    logic        instr_gnt;
    instr_t      instr_rdata;
    logic        instr_rvalid;

    // data port
    logic        data_req;
    data_req_t   data_req_bits;
    logic        data_gnt;
    logic [31:0] data_rdata;
    logic        data_rvalid;

    mini_core u_core (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .fetch_enable_i  (fetch_enable_i),
        .instr_req_o     (instr_req),
        .instr_addr_o    (instr_addr),
        .instr_gnt_i     (instr_gnt),
        .instr_rdata_i   (instr_rdata),
        .instr_rvalid_i  (instr_rvalid),
        .data_req_o      (data_req),
        .data_req_o_bits (data_req_bits),
        .data_gnt_i      (data_gnt),
        .data_rdata_i    (data_rdata),
        .data_rvalid_i   (data_rvalid)
    );

    // RAM plus print and exit ports
    mm_ram u_ram (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .load_valid_i    (load_valid_i),
        .load_i          (load_i),
        .instr_req_i     (instr_req),
        .instr_addr_i    (instr_addr),
        .instr_gnt_o     (instr_gnt),
        .instr_rdata_o   (instr_rdata),
        .instr_rvalid_o  (instr_rvalid),
        .data_req_i      (data_req),
        .data_req_i_bits (data_req_bits),
        .data_gnt_o      (data_gnt),
        .data_rdata_o    (data_rdata),
        .data_rvalid_o   (data_rvalid),
        .print_valid_o   (print_valid_o),
        .print_char_o    (print_char_o),
        .tests_passed_o  (tests_passed_o),
        .tests_failed_o  (tests_failed_o),
        .exit_valid_o    (exit_valid_o),
        .exit_value_o    (exit_value_o)
    );

    // program load only while the core is held
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        load_valid_i |-> !fetch_enable_i);

endmodule

/* dv/tb_clk_gen.sv */
// Testbench clock and reset

`timescale 1ns/1ns

module tb_clk_gen (
    input  logic reset_req_i,
    output logic clk_o,
    output logic rst_n_o
);

    logic       clk = 1'b0;
    logic       rst_n = 1'b0;
    logic [2:0] hold_q = 3'd4;

    assign clk_o   = clk;
    assign rst_n_o = rst_n;

    // 8 ns period
    always #4 clk = ~clk;

    // reset stays low for four rising edges after power-up and after each request
    always @(posedge clk) begin
        if (reset_req_i) begin
            hold_q <= 3'd4;
            rst_n  <= 1'b0;
        end else if (hold_q != 3'd0) begin
            hold_q <= hold_q - 3'd1;
            rst_n  <= (hold_q == 3'd1);
        end
    end

endmodule

/* dv/tb_top.sv */
// Accumulator subsystem testbench

`timescale 1ns/1ns

module tb_top import mini_pkg::*; ();

    localparam int WAIT_LIMIT = 2000;
    localparam logic [23:0] DATA_BASE = 24'h00_1000;

    logic        clk;
    logic        rst_n;
    logic        reset_req;

    logic        fetch_enable;
    logic        load_valid;
    load_t       load;
    logic        print_valid;
    logic [7:0]  print_char;
    logic        tests_passed;
    logic        tests_failed;
    logic        exit_valid;
    logic [31:0] exit_value;

    // program image, loaded from address 0
    instr_t      prog_q[$];
    // characters seen on the print port, oldest first
    logic [7:0]  chars_q[$];

    tb_clk_gen u_clk_gen (
        .reset_req_i (reset_req),
        .clk_o       (clk),
        .rst_n_o     (rst_n)
    );

    mini_subsystem u_dut (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .fetch_enable_i (fetch_enable),
        .load_valid_i   (load_valid),
        .load_i         (load),
        .print_valid_o  (print_valid),
        .print_char_o   (print_char),
        .tests_passed_o (tests_passed),
        .tests_failed_o (tests_failed),
        .exit_valid_o   (exit_valid),
        .exit_value_o   (exit_value)
    );

    // print strobes are collected on the falling edge
    always @(negedge clk) begin
        if (rst_n && print_valid) begin
            chars_q.push_back(print_char);
        end
    end

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string msg);
        stop_with_error($sformatf("mismatch at %0t ns: %s", $time, msg));
    endtask

    // immediates are 24 bits wide and sign extended by the core
    function automatic logic [31:0] sign_extend(input logic [23:0] imm);
        return {{8{imm[23]}}, imm};
    endfunction

    function automatic instr_t make_instr(input opcode_e op, input logic [23:0] operand);
        instr_t word;
        word.opcode  = op;
        word.operand = operand;
        return word;
    endfunction

    function automatic logic [23:0] next_addr();
        return 24'(prog_q.size() * 4);
    endfunction

    function automatic void emit(input opcode_e op, input logic [23:0] operand);
        prog_q.push_back(make_instr(op, operand));
    endfunction

    // jump to itself so the core never runs into stale words
    function automatic void emit_halt();
        emit(OP_JMP, next_addr());
    endfunction

    task automatic reset_dut();
        int cycles;
        cycles = 0;
        @(posedge clk);
        fetch_enable <= 1'b0;
        load_valid   <= 1'b0;
        reset_req    <= 1'b1;
        @(posedge clk);
        reset_req <= 1'b0;
        @(negedge clk);
        while (!rst_n) begin
            @(negedge clk);
            cycles++;
            if (cycles > 20) begin
                stop_with_error("reset was never released");
            end
        end
        chars_q.delete();
        prog_q.delete();
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        load_valid <= 1'b1;
        load.addr  <= addr;
        load.data  <= data;
        @(posedge clk);
        load_valid <= 1'b0;
    endtask

    task automatic load_program();
        foreach (prog_q[i]) begin
            write_word(32'(i * 4), prog_q[i]);
        end
        @(posedge clk);
        fetch_enable <= 1'b1;
    endtask

    task automatic wait_exit();
        int cycles;
        cycles = 0;
        while (!exit_valid) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                stop_with_error("timed out waiting for the exit port");
            end
        end
    endtask

    task automatic check_exit(input logic [31:0] exp_value, input logic exp_pass);
        if (exit_valid !== 1'b1) begin
            report_mismatch("exit_valid_o is not set");
        end
        if (exit_value !== exp_value) begin
            report_mismatch($sformatf("exit value %h, expected %h", exit_value, exp_value));
        end
        if (tests_passed !== exp_pass || tests_failed !== !exp_pass) begin
            report_mismatch($sformatf("passed %b failed %b, expected pass flag %b",
                tests_passed, tests_failed, exp_pass));
        end
    endtask

    task automatic check_char(input logic [7:0] exp_char);
        int cycles;
        logic [7:0] got;
        cycles = 0;
        while (chars_q.size() == 0) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                stop_with_error("timed out waiting for a character");
            end
        end
        got = chars_q.pop_front();
        if (got !== exp_char) begin
            report_mismatch($sformatf("character %h, expected %h", got, exp_char));
        end
    endtask

    task automatic expect_no_chars();
        if (chars_q.size() != 0) begin
            stop_with_error("the print port produced characters that no store asked for");
        end
    endtask

    task automatic immediate_arith();
        reset_dut();
        // accumulator made non-zero first so the load of zero shows
        emit(OP_ADDI, 24'd3);
        emit(OP_LDI, 24'd0);
        emit(OP_NOP, 24'd0);
        emit(OP_ST, EXIT_ADDR);
        emit_halt();
        load_program();
        wait_exit();
        check_exit(32'd0, 1'b1);
        expect_no_chars();
    endtask

    task automatic memory_round_trip();
        logic [23:0] imm_a;
        logic [23:0] imm_b;
        logic [31:0] word_c;
        logic [31:0] sum;
        imm_a  = 24'($urandom);
        imm_b  = 24'($urandom);
        word_c = $urandom;
        reset_dut();
        // third operand is a full word placed by the load port
        write_word({8'h00, DATA_BASE + 24'd8}, word_c);
        emit(OP_LDI, imm_a);
        emit(OP_ST, DATA_BASE);
        emit(OP_LDI, imm_b);
        emit(OP_ST, DATA_BASE + 24'd4);
        emit(OP_LDI, 24'd0);
        emit(OP_LD, DATA_BASE);
        emit(OP_ADD, DATA_BASE + 24'd4);
        emit(OP_ADD, DATA_BASE + 24'd8);
        emit(OP_ST, EXIT_ADDR);
        emit_halt();
        load_program();
        sum = sign_extend(imm_a) + sign_extend(imm_b) + word_c;
        wait_exit();
        check_exit(sum, sum == 32'd0);
        expect_no_chars();
    endtask

    task automatic counting_loop();
        int n;
        logic [23:0] loop_addr;
        n = 3 + int'($urandom % 6);
        reset_dut();
        emit(OP_LDI, 24'(n));
        loop_addr = next_addr();
        emit(OP_ST, PRINT_ADDR);
        emit(OP_ADDI, 24'hFF_FFFF);
        emit(OP_BNZ, loop_addr);
        emit(OP_ST, EXIT_ADDR);
        emit_halt();
        load_program();
        for (int k = n; k >= 1; k--) begin
            check_char(8'(k));
        end
        wait_exit();
        check_exit(32'd0, 1'b1);
        expect_no_chars();
    endtask

    task automatic failing_exit();
        logic [31:0] value;
        value = $urandom;
        if (value == 32'd0) begin
            value = 32'd1;
        end
        reset_dut();
        write_word({8'h00, DATA_BASE}, value);
        emit(OP_LD, DATA_BASE);
        emit(OP_ST, EXIT_ADDR);
        emit_halt();
        load_program();
        wait_exit();
        check_exit(value, 1'b0);
        expect_no_chars();
    endtask

    task automatic sticky_exit();
        reset_dut();
        // the skipped block would report exit 9
        emit(OP_JMP, 24'd12);
        emit(OP_LDI, 24'd9);
        emit(OP_ST, EXIT_ADDR);
        emit(OP_LDI, 24'd5);
        emit(OP_ST, EXIT_ADDR);
        emit(OP_LDI, 24'd0);
        emit(OP_ST, EXIT_ADDR);
        // marker character shows the second exit store is done
        emit(OP_LDI, 24'h00_005A);
        emit(OP_ST, PRINT_ADDR);
        emit_halt();
        load_program();
        wait_exit();
        check_exit(32'd5, 1'b0);
        check_char(8'h5A);
        check_exit(32'd5, 1'b0);
        expect_no_chars();
    endtask

    initial begin
        void'($urandom(32'h792261a2));
        reset_req    = 1'b0;
        fetch_enable = 1'b0;
        load_valid   = 1'b0;
        load         = '0;

        immediate_arith();
        memory_round_trip();
        counting_loop();
        failing_exit();
        sticky_exit();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* all.f */
hw/mini_pkg.sv
hw/mini_core.sv
hw/mm_ram.sv
hw/mini_subsystem.sv
dv/tb_clk_gen.sv
dv/tb_top.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the accumulator subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert --top-module tb_top -f all.f -o tb_top_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator compile failed with status $status"
    exit 1
fi

./obj_dir/tb_top_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "SIMULATION PASSED" "$LOG"; then
    echo "run_sim: pass"
    exit 0
else
    echo "run_sim: pass message not found in $LOG"
    exit 1
fi
